//--- files.f
hdl/tcdm_pkg.sv
hdl/amo_alu.sv
hdl/amo_unit.sv
hdl/lrsc_reservation.sv
hdl/resp_buffer.sv
hdl/tcdm_adapter.sv
tb/tb_tcdm_adapter.sv

//--- Makefile
# Verilator build and run of the adapter testbench

SIM = obj_dir/Vtb_tcdm_adapter

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM): files.f $(wildcard hdl/*.sv) $(wildcard tb/*.sv)
	verilator --binary --timing --assert --top-module tb_tcdm_adapter -f files.f

# passes only if the pass line shows up in the output
run: $(SIM)
	./$(SIM) | awk '{ print } /^Test completed successfully$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir

//--- tb/tb_tcdm_adapter.sv
/* memory-bank adapter testbench with SRAM model, clock and reset,
   stimulus table with expected responses, back-pressure stalls and watchdog */
`timescale 1ns/1ps

module tb_tcdm_adapter;

  import tcdm_pkg::*;

  localparam int unsigned addr_width   = 10;
  localparam int unsigned clk_period   = 100;
  localparam int unsigned reset_cycles = 10;
  localparam int unsigned sram_words   = 1024;

  // one table row with request, expected response and stall flag
  typedef struct packed {
    amo_op_t               op;
    logic                  write;
    logic [addr_width-1:0] addr;
    logic [be_width-1:0]   be;
    logic [data_width-1:0] wdata;
    logic [3:0]            core;
    logic [3:0]            tag;
    logic                  resp;
    logic [data_width-1:0] exp_rdata;
    logic                  stall;
  } row_t;

  logic                  clk_i;
  logic                  rst_ni;
  logic                  in_valid_i;
  logic                  in_ready_o;
  logic [addr_width-1:0] in_address_i;
  amo_op_t               in_amo_i;
  logic                  in_write_i;
  logic [data_width-1:0] in_wdata_i;
  logic [be_width-1:0]   in_be_i;
  meta_t                 in_meta_i;
  logic                  in_valid_o;
  logic                  in_ready_i;
  logic [data_width-1:0] in_rdata_o;
  meta_t                 in_meta_o;
  logic                  out_req_o;
  logic [addr_width-1:0] out_add_o;
  logic                  out_write_o;
  logic [data_width-1:0] out_wdata_o;
  logic [be_width-1:0]   out_be_o;
  logic [data_width-1:0] out_rdata_i;

  logic [data_width-1:0] sram [sram_words];
  row_t                  rows [$];
  int unsigned           n_rows = 0;

  tcdm_adapter dut (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .in_address_i(in_address_i),
    .in_amo_i    (in_amo_i),
    .in_write_i  (in_write_i),
    .in_wdata_i  (in_wdata_i),
    .in_be_i     (in_be_i),
    .in_meta_i   (in_meta_i),
    .in_valid_o  (in_valid_o),
    .in_ready_i  (in_ready_i),
    .in_rdata_o  (in_rdata_o),
    .in_meta_o   (in_meta_o),
    .out_req_o   (out_req_o),
    .out_add_o   (out_add_o),
    .out_write_o (out_write_o),
    .out_wdata_o (out_wdata_o),
    .out_be_o    (out_be_o),
    .out_rdata_i (out_rdata_i)
  );

  // --------------------
  // clock and SRAM model
  // --------------------

  initial begin
    clk_i = 1'b0;
    forever #(clk_period / 2) clk_i = ~clk_i;
  end

  // every word starts with its own address in both halves
  initial begin
    out_rdata_i = '0;
    for (int i = 0; i < sram_words; i++) begin
      sram[i] = {6'h2a, i[9:0], 6'h15, i[9:0]};
    end
  end

  // read data shows up the cycle after the request
  always @(posedge clk_i) begin
    if (out_req_o) begin
      if (out_write_o) begin
        for (int b = 0; b < be_width; b++) begin
          if (out_be_o[b]) begin
            sram[out_add_o][8*b +: 8] <= out_wdata_o[8*b +: 8];
          end
        end
      end else begin
        out_rdata_i <= sram[out_add_o];
      end
    end
  end

  // --------------------
  // helpers
  // --------------------

  task automatic check(input logic ok, input string what);
    assert (ok) else begin
      $display("FAILED at %0t ns: %s", $time, what);
      $display("Test failed");
      $fatal(1, "stopping at the first error");
    end
  endtask

  function automatic void add_row(input amo_op_t op, input int unsigned write,
                                  input int unsigned addr, input logic [3:0] be,
                                  input logic [31:0] wdata, input int unsigned core,
                                  input int unsigned tag, input int unsigned resp,
                                  input logic [31:0] exp_rdata, input int unsigned stall);
    row_t r;
    r.op        = op;
    r.write     = (write != 0);
    r.addr      = addr[addr_width-1:0];
    r.be        = be;
    r.wdata     = wdata;
    r.core      = core[3:0];
    r.tag       = tag[3:0];
    r.resp      = (resp != 0);
    r.exp_rdata = exp_rdata;
    r.stall     = (stall != 0);
    rows.push_back(r);
  endfunction

  // drive one request and hold it until the adapter takes it
  task automatic apply_request(input row_t r);
    @(posedge clk_i);
    #1;
    in_valid_i        = 1'b1;
    in_amo_i          = r.op;
    in_write_i        = r.write;
    in_address_i      = r.addr;
    in_be_i           = r.be;
    in_wdata_i        = r.wdata;
    in_meta_i.core_id = r.core;
    in_meta_i.tag     = r.tag;
    in_ready_i        = !r.stall;
    @(negedge clk_i);
    while (!in_ready_o) begin
      @(negedge clk_i);
    end
    // accepted at this edge
    @(posedge clk_i);
    #1;
    in_valid_i = 1'b0;
  endtask

  // compare the response, stall it if asked, and see it leave once
  task automatic collect_response(input int idx, input row_t r);
    int unsigned           latency;
    int unsigned           stall_cycles;
    logic [data_width-1:0] held_data;
    meta_t                 held_meta;
    latency = 0;
    @(negedge clk_i);
    while (!in_valid_o) begin
      latency++;
      @(negedge clk_i);
    end
    check(latency == 0, $sformatf("row %0d response %0d cycles late", idx, latency));
    check(in_rdata_o == r.exp_rdata,
          $sformatf("row %0d rdata %h, expected %h", idx, in_rdata_o, r.exp_rdata));
    check(in_meta_o.core_id == r.core && in_meta_o.tag == r.tag,
          $sformatf("row %0d meta %h, expected core %h tag %h", idx, in_meta_o,
                    r.core, r.tag));
    // sequencer is busy right after an atomic is taken
    if (!(r.op inside {amo_none, amo_lr, amo_sc})) begin
      check(!in_ready_o, $sformatf("row %0d in_ready_o high during atomic", idx));
    end
    if (r.stall) begin
      held_data    = in_rdata_o;
      held_meta    = in_meta_o;
      stall_cycles = ($urandom % 8) + 1;
      repeat (stall_cycles) begin
        @(negedge clk_i);
        check(in_valid_o && in_rdata_o == held_data && in_meta_o == held_meta,
              $sformatf("row %0d response changed while stalled", idx));
        check(!in_ready_o, $sformatf("row %0d in_ready_o high while stalled", idx));
      end
      @(posedge clk_i);
      #1;
      in_ready_i = 1'b1;
      @(negedge clk_i);
      check(in_valid_o, $sformatf("row %0d response lost after stall", idx));
    end
    // handshake completes on this edge
    @(posedge clk_i);
    @(negedge clk_i);
    check(!in_valid_o, $sformatf("row %0d response delivered twice", idx));
  endtask

  // --------------------
  // stimulus table
  // --------------------

  function automatic void fill_table();
    // op, write, addr, be, wdata, core, tag, resp, expected rdata, stall
    // plain stores and loads with byte enables
    add_row(amo_none, 1, 'h010, 4'hf, 32'h1234_5678, 0, 0, 0, 32'h0000_0000, 0);
    add_row(amo_none, 1, 'h010, 4'h5, 32'haabb_ccdd, 0, 1, 0, 32'h0000_0000, 0);
    add_row(amo_none, 0, 'h010, 4'hf, 32'h0000_0000, 3, 5, 1, 32'h12bb_56dd, 0);
    add_row(amo_none, 0, 'h3ff, 4'hf, 32'h0000_0000, 2, 9, 1, 32'habff_57ff, 0);
    // atomic chain, each returns the old word
    add_row(amo_none, 1, 'h020, 4'hf, 32'h0000_0010, 0, 0, 0, 32'h0000_0000, 0);
    add_row(amo_swap, 0, 'h020, 4'hf, 32'h8000_0005, 1, 1, 1, 32'h0000_0010, 0);
    add_row(amo_none, 0, 'h020, 4'hf, 32'h0000_0000, 1, 2, 1, 32'h8000_0005, 0);
    add_row(amo_add,  0, 'h020, 4'hf, 32'h7fff_ffff, 2, 3, 1, 32'h8000_0005, 0);
    add_row(amo_none, 0, 'h020, 4'hf, 32'h0000_0000, 2, 4, 1, 32'h0000_0004, 0);
    add_row(amo_or,   0, 'h020, 4'hf, 32'hf0f0_0003, 3, 5, 1, 32'h0000_0004, 0);
    add_row(amo_none, 0, 'h020, 4'hf, 32'h0000_0000, 3, 6, 1, 32'hf0f0_0007, 0);
    add_row(amo_and,  0, 'h020, 4'hf, 32'h0fff_ff0e, 4, 7, 1, 32'hf0f0_0007, 0);
    add_row(amo_none, 0, 'h020, 4'hf, 32'h0000_0000, 4, 8, 1, 32'h00f0_0006, 0);
    add_row(amo_xor,  0, 'h020, 4'hf, 32'hffff_ffff, 5, 9, 1, 32'h00f0_0006, 0);
    add_row(amo_none, 0, 'h020, 4'hf, 32'h0000_0000, 5, 10, 1, 32'hff0f_fff9, 0);
    // signed and unsigned compares with the sign bit set
    add_row(amo_max,  0, 'h020, 4'hf, 32'h0000_0100, 6, 11, 1, 32'hff0f_fff9, 0);
    add_row(amo_none, 0, 'h020, 4'hf, 32'h0000_0000, 6, 12, 1, 32'h0000_0100, 0);
    add_row(amo_maxu, 0, 'h020, 4'hf, 32'h8000_0000, 7, 13, 1, 32'h0000_0100, 0);
    add_row(amo_none, 0, 'h020, 4'hf, 32'h0000_0000, 7, 14, 1, 32'h8000_0000, 0);
    add_row(amo_minu, 0, 'h020, 4'hf, 32'h0000_0001, 8, 15, 1, 32'h8000_0000, 0);
    add_row(amo_none, 0, 'h020, 4'hf, 32'h0000_0000, 8, 0, 1, 32'h0000_0001, 0);
    add_row(amo_min,  0, 'h020, 4'hf, 32'hffff_fffe, 9, 1, 1, 32'h0000_0001, 0);
    add_row(amo_none, 0, 'h020, 4'hf, 32'h0000_0000, 9, 2, 1, 32'hffff_fffe, 0);
    // LR then SC from one core, then a second SC fails
    add_row(amo_none, 1, 'h030, 4'hf, 32'h0000_0aaa, 0, 0, 0, 32'h0000_0000, 0);
    add_row(amo_lr,   0, 'h030, 4'hf, 32'h0000_0000, 1, 2, 1, 32'h0000_0aaa, 0);
    add_row(amo_sc,   1, 'h030, 4'hf, 32'h0000_0bbb, 1, 3, 1, 32'h0000_0000, 0);
    add_row(amo_none, 0, 'h030, 4'hf, 32'h0000_0000, 1, 4, 1, 32'h0000_0bbb, 0);
    add_row(amo_sc,   1, 'h030, 4'hf, 32'h0000_0ccc, 1, 5, 1, 32'h0000_0001, 0);
    add_row(amo_none, 0, 'h030, 4'hf, 32'h0000_0000, 1, 6, 1, 32'h0000_0bbb, 0);
    // store by another core breaks the reservation
    add_row(amo_none, 1, 'h040, 4'hf, 32'h1111_1111, 0, 0, 0, 32'h0000_0000, 0);
    add_row(amo_lr,   0, 'h040, 4'hf, 32'h0000_0000, 1, 7, 1, 32'h1111_1111, 0);
    add_row(amo_none, 1, 'h040, 4'hf, 32'h2222_2222, 2, 8, 0, 32'h0000_0000, 0);
    add_row(amo_sc,   1, 'h040, 4'hf, 32'h3333_3333, 1, 9, 1, 32'h0000_0001, 0);
    add_row(amo_none, 0, 'h040, 4'hf, 32'h0000_0000, 1, 10, 1, 32'h2222_2222, 0);
    // second core cannot take over a held reservation
    add_row(amo_none, 1, 'h050, 4'hf, 32'h0000_0050, 0, 0, 0, 32'h0000_0000, 0);
    add_row(amo_lr,   0, 'h050, 4'hf, 32'h0000_0000, 1, 11, 1, 32'h0000_0050, 0);
    add_row(amo_lr,   0, 'h050, 4'hf, 32'h0000_0000, 2, 12, 1, 32'h0000_0050, 0);
    add_row(amo_sc,   1, 'h050, 4'hf, 32'h0000_0002, 2, 13, 1, 32'h0000_0001, 0);
    add_row(amo_sc,   1, 'h050, 4'hf, 32'h0000_0001, 1, 14, 1, 32'h0000_0000, 0);
    add_row(amo_none, 0, 'h050, 4'hf, 32'h0000_0000, 1, 15, 1, 32'h0000_0001, 0);
    // responses held back by the core
    add_row(amo_none, 0, 'h010, 4'hf, 32'h0000_0000, 5, 10, 1, 32'h12bb_56dd, 1);
    add_row(amo_add,  0, 'h020, 4'hf, 32'h0000_0002, 6, 11, 1, 32'hffff_fffe, 1);
    add_row(amo_none, 0, 'h020, 4'hf, 32'h0000_0000, 6, 12, 1, 32'h0000_0000, 0);
    add_row(amo_lr,   0, 'h060, 4'hf, 32'h0000_0000, 3, 13, 1, 32'ha860_5460, 1);
    add_row(amo_sc,   1, 'h060, 4'hf, 32'h0000_0006, 3, 14, 1, 32'h0000_0000, 1);
    add_row(amo_none, 0, 'h060, 4'hf, 32'h0000_0000, 3, 15, 1, 32'h0000_0006, 0);
  endfunction

  // --------------------
  // main sequence
  // --------------------

  initial begin
    void'($urandom(32'h3b00_9378));
    rst_ni       = 1'b0;
    in_valid_i   = 1'b0;
    in_address_i = '0;
    in_amo_i     = amo_none;
    in_write_i   = 1'b0;
    in_wdata_i   = '0;
    in_be_i      = '0;
    in_meta_i    = '0;
    in_ready_i   = 1'b1;
    fill_table();
    n_rows = rows.size();
    repeat (reset_cycles) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    @(negedge clk_i);
    check(!in_valid_o && !out_req_o && in_ready_o, "adapter not idle after reset");
    foreach (rows[i]) begin
      apply_request(rows[i]);
      if (rows[i].resp) begin
        collect_response(i, rows[i]);
      end else begin
        @(negedge clk_i);
        check(!in_valid_o, $sformatf("row %0d store produced a response", i));
      end
    end
    $display("Test completed successfully");
    $finish;
  end

  // run budget scales with the table
  initial begin
    wait (n_rows != 0);
    #(n_rows * 20 * clk_period);
    $display("timeout: the run did not finish within %0d cycles", n_rows * 20);
    $display("Test failed");
    $fatal(1, "watchdog expired");
  end

endmodule

//--- hdl/tcdm_adapter.sv
/* memory-bank adapter top: request path, SRAM port mux and response push,
   around the LR/SC reservation, atomic sequencer and response buffer */
`timescale 1ns/1ps

module tcdm_adapter #(
  parameter int unsigned AddrWidth   = 10,
  parameter bit          RegisterAmo = 1'b0
) (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  // core side request
  input  logic                            in_valid_i,
  output logic                            in_ready_o,
  input  logic [AddrWidth-1:0]            in_address_i,
  input  tcdm_pkg::amo_op_t               in_amo_i,
  input  logic                            in_write_i,
  input  logic [tcdm_pkg::data_width-1:0] in_wdata_i,
  input  logic [tcdm_pkg::be_width-1:0]   in_be_i,
  input  tcdm_pkg::meta_t                 in_meta_i,
  // core side response
  output logic                            in_valid_o,
  input  logic                            in_ready_i,
  output logic [tcdm_pkg::data_width-1:0] in_rdata_o,
  output tcdm_pkg::meta_t                 in_meta_o,
  // SRAM side
  output logic                            out_req_o,
  output logic [AddrWidth-1:0]            out_add_o,
  output logic                            out_write_o,
  output logic [tcdm_pkg::data_width-1:0] out_wdata_o,
  output logic [tcdm_pkg::be_width-1:0]   out_be_o,
  input  logic [tcdm_pkg::data_width-1:0] out_rdata_i
);

  import tcdm_pkg::*;

  // request decode
  logic accept;
  logic is_store;
  logic is_sc;
  logic is_amo;

  // store-conditional status, used one cycle later
  logic sc_success;
  logic sc_q;
  logic sc_success_q;

  // atomic write-back command
  logic                  amo_busy;
  logic [AddrWidth-1:0]  wb_addr;
  logic [data_width-1:0] wb_data;

  // response push toward the buffer
  logic                  push_q;
  logic [data_width-1:0] push_data;

  // --------------------
  // request side
  // --------------------

  // a held response or a running atomic stalls new requests
  assign in_ready_o = !amo_busy && !(in_valid_o && !in_ready_i);
  assign accept     = in_valid_i && in_ready_o;

  assign is_store = in_write_i && (in_amo_i == amo_none);
  assign is_sc    = (in_amo_i == amo_sc);
  assign is_amo   = !(in_amo_i inside {amo_none, amo_lr, amo_sc});

  always_comb begin
    if (amo_busy) begin
      // sequencer owns the port for its write-back
      out_req_o   = 1'b1;
      out_write_o = 1'b1;
      out_add_o   = wb_addr;
      out_wdata_o = wb_data;
      out_be_o    = '1;
    end else begin
      // failed SC never reaches the bank
      out_req_o   = accept && !(is_sc && !sc_success);
      out_write_o = is_store || is_sc;
      out_add_o   = in_address_i;
      out_wdata_o = in_wdata_i;
      out_be_o    = in_be_i;
    end
  end

  // --------------------
  // response side
  // --------------------

  // reads return data next cycle, an SC returns its status instead
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      push_q       <= 1'b0;
      sc_q         <= 1'b0;
      sc_success_q <= 1'b0;
    end else begin
      push_q       <= (out_req_o && !out_write_o) || (accept && is_sc);
      sc_q         <= accept && is_sc;
      sc_success_q <= sc_success;
    end
  end

  // 0 on success, 1 on failure
  assign push_data = sc_q ? {{(data_width-1){1'b0}}, !sc_success_q} : out_rdata_i;

  lrsc_reservation #(
    .AddrWidth(AddrWidth)
  ) i_lrsc (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .accept_i    (accept),
    .op_i        (in_amo_i),
    .write_i     (is_store),
    .addr_i      (in_address_i),
    .core_i      (in_meta_i.core_id),
    .sc_success_o(sc_success)
  );

  amo_unit #(
    .AddrWidth  (AddrWidth),
    .RegisterAmo(RegisterAmo)
  ) i_amo (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .start_i    (accept && is_amo),
    .op_i       (in_amo_i),
    .addr_i     (in_address_i),
    .operand_i  (in_wdata_i),
    .mem_rdata_i(out_rdata_i),
    .busy_o     (amo_busy),
    .wb_addr_o  (wb_addr),
    .wb_data_o  (wb_data)
  );

  resp_buffer i_resp (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .meta_push_i(accept && !is_store),
    .meta_i     (in_meta_i),
    .data_push_i(push_q),
    .data_i     (push_data),
    .valid_o    (in_valid_o),
    .ready_i    (in_ready_i),
    .rdata_o    (in_rdata_o),
    .meta_o     (in_meta_o)
  );

endmodule

//--- hdl/resp_buffer.sv
/* response buffer: two-entry metadata store paired with a
   fall-through read-data register */
`timescale 1ns/1ps

module resp_buffer (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  // metadata arrives at request acceptance
  input  logic                            meta_push_i,
  input  tcdm_pkg::meta_t                 meta_i,
  // data arrives one cycle later
  input  logic                            data_push_i,
  input  logic [tcdm_pkg::data_width-1:0] data_i,
  // response handshake
  output logic                            valid_o,
  input  logic                            ready_i,
  output logic [tcdm_pkg::data_width-1:0] rdata_o,
  output tcdm_pkg::meta_t                 meta_o
);

  import tcdm_pkg::*;

  // --------------------
  // metadata store
  // --------------------

  meta_t      meta_mem [2];
  logic       wr_ptr_q;
  logic       rd_ptr_q;
  logic [1:0] count_q;
  logic       meta_valid;

  // --------------------
  // data register
  // --------------------

  logic                  data_full_q;
  logic [data_width-1:0] data_q;
  logic                  data_valid;

  logic pop;

  assign meta_valid = (count_q != 2'd0);
  assign meta_o     = meta_mem[rd_ptr_q];

  // empty register passes the incoming word straight through
  assign data_valid = data_full_q || data_push_i;
  assign rdata_o    = data_full_q ? data_q : data_i;

  // both halves are needed and leave together
  assign valid_o = meta_valid && data_valid;
  assign pop     = valid_o && ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q    <= 1'b0;
      rd_ptr_q    <= 1'b0;
      count_q     <= 2'd0;
      data_full_q <= 1'b0;
    end else begin
      if (meta_push_i) begin
        wr_ptr_q <= !wr_ptr_q;
      end
      if (pop) begin
        rd_ptr_q <= !rd_ptr_q;
      end
      count_q <= count_q + {1'b0, meta_push_i} - {1'b0, pop};
      // held word stays until popped, a pushed word stays unless taken at once
      if (data_full_q) begin
        data_full_q <= !pop || data_push_i;
      end else begin
        data_full_q <= data_push_i && !pop;
      end
    end
  end

  // storage only, the counters above say what is valid
  always_ff @(posedge clk_i) begin
    if (meta_push_i) begin
      meta_mem[wr_ptr_q] <= meta_i;
    end
    if (data_push_i && (data_full_q ? pop : !pop)) begin
      data_q <= data_i;
    end
  end

endmodule

//--- hdl/lrsc_reservation.sv
/* single LR reservation and the store-conditional success decision */
`timescale 1ns/1ps

module lrsc_reservation #(
  parameter int unsigned AddrWidth = 10
) (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  logic                               accept_i,
  input  tcdm_pkg::amo_op_t                  op_i,
  input  logic                               write_i,
  input  logic [AddrWidth-1:0]               addr_i,
  input  logic [tcdm_pkg::core_id_width-1:0] core_i,
  output logic                               sc_success_o
);

  import tcdm_pkg::*;

  // reservation: valid, address and owning core
  logic                     valid_q, valid_d;
  logic [AddrWidth-1:0]     addr_q, addr_d;
  logic [core_id_width-1:0] core_q, core_d;

  logic owner;
  logic is_amo;

  assign owner  = valid_q && (core_q == core_i);
  assign is_amo = !(op_i inside {amo_none, amo_lr, amo_sc});

  always_comb begin
    valid_d      = valid_q;
    addr_d       = addr_q;
    core_d       = core_q;
    sc_success_o = 1'b0;
    if (accept_i) begin
      // another core cannot steal a held reservation
      if (op_i == amo_lr && (!valid_q || owner)) begin
        valid_d = 1'b1;
        addr_d  = addr_i;
        core_d  = core_i;
      end
      // any store or atomic to the reserved word breaks it
      if (addr_i == addr_q && (write_i || is_amo)) begin
        valid_d = 1'b0;
      end
      // SC from the owner always consumes the reservation
      if (op_i == amo_sc && owner) begin
        valid_d      = 1'b0;
        sc_success_o = (addr_i == addr_q);
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= valid_d;
    end
  end

  always_ff @(posedge clk_i) begin
    addr_q <= addr_d;
    core_q <= core_d;
  end

endmodule

//--- hdl/amo_unit.sv
/* atomic sequencer: captures the operation, claims the SRAM port
   and writes the ALU result back */
`timescale 1ns/1ps

module amo_unit #(
  parameter int unsigned AddrWidth   = 10,
  parameter bit          RegisterAmo = 1'b0
) (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            start_i,
  input  tcdm_pkg::amo_op_t               op_i,
  input  logic [AddrWidth-1:0]            addr_i,
  input  logic [tcdm_pkg::data_width-1:0] operand_i,
  input  logic [tcdm_pkg::data_width-1:0] mem_rdata_i,
  output logic                            busy_o,
  output logic [AddrWidth-1:0]            wb_addr_o,
  output logic [tcdm_pkg::data_width-1:0] wb_data_o
);

  import tcdm_pkg::*;

  amo_state_t state_q, state_d;

  // captured operation
  amo_op_t               op_q;
  logic [AddrWidth-1:0]  addr_q;
  logic [data_width-1:0] operand_q;

  // new memory word
  logic [data_width-1:0] alu_result;
  logic [data_width-1:0] result_q;

  // --------------------
  // FSM
  // --------------------

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      idle: begin
        if (start_i) begin
          state_d = do_amo;
        end
      end
      // old word is on mem_rdata_i here
      do_amo: begin
        state_d = RegisterAmo ? write_back : idle;
      end
      write_back: begin
        state_d = idle;
      end
      default: begin
        state_d = idle;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= idle;
      op_q    <= amo_none;
    end else begin
      state_q <= state_d;
      if (start_i) begin
        op_q <= op_i;
      end
    end
  end

  // address, operand and result are payload only
  always_ff @(posedge clk_i) begin
    if (start_i) begin
      addr_q    <= addr_i;
      operand_q <= operand_i;
    end
    if (state_q == do_amo) begin
      result_q <= alu_result;
    end
  end

  amo_alu i_alu (
    .op_i     (op_q),
    .mem_i    (mem_rdata_i),
    .operand_i(operand_q),
    .result_o (alu_result)
  );

  // --------------------
  // write-back command
  // --------------------

  assign busy_o    = (state_q != idle);
  assign wb_addr_o = addr_q;

  // with the cut path, do_amo rewrites the unchanged old word
  // and the real result follows from the register in write_back
  always_comb begin
    if (!RegisterAmo) begin
      wb_data_o = alu_result;
    end else if (state_q == write_back) begin
      wb_data_o = result_q;
    end else begin
      wb_data_o = mem_rdata_i;
    end
  end

endmodule

//--- hdl/amo_alu.sv
/* atomic arithmetic on the old memory word and the request operand */
`timescale 1ns/1ps

module amo_alu (
  input  tcdm_pkg::amo_op_t               op_i,
  input  logic [tcdm_pkg::data_width-1:0] mem_i,
  input  logic [tcdm_pkg::data_width-1:0] operand_i,
  output logic [tcdm_pkg::data_width-1:0] result_o
);

  import tcdm_pkg::*;

  // compare ops run the adder as mem - operand
  logic is_cmp;
  logic is_unsigned;

  // one extra bit keeps the sign of the difference
  logic [data_width:0] ext_mem;
  logic [data_width:0] ext_operand;
  logic [data_width:0] adder_b;
  logic [data_width:0] sum;

  // mem below operand in the chosen signedness
  logic less;

  assign is_cmp      = op_i inside {amo_max, amo_maxu, amo_min, amo_minu};
  assign is_unsigned = op_i inside {amo_maxu, amo_minu};

  // sign extension unless an unsigned compare
  assign ext_mem     = {mem_i[data_width-1] & !is_unsigned, mem_i};
  assign ext_operand = {operand_i[data_width-1] & !is_unsigned, operand_i};

  // two's complement subtract by inversion plus carry in
  assign adder_b = is_cmp ? ~ext_operand : ext_operand;
  assign sum     = ext_mem + adder_b + {{data_width{1'b0}}, is_cmp};
  assign less    = sum[data_width];

  always_comb begin
    unique case (op_i)
      amo_swap: result_o = operand_i;
      amo_add:  result_o = sum[data_width-1:0];
      amo_and:  result_o = mem_i & operand_i;
      amo_or:   result_o = mem_i | operand_i;
      amo_xor:  result_o = mem_i ^ operand_i;
      // larger of the two
      amo_max, amo_maxu: begin
        result_o = less ? operand_i : mem_i;
      end
      // smaller of the two
      amo_min, amo_minu: begin
        result_o = less ? mem_i : operand_i;
      end
      // not an atomic, nothing to write
      default: result_o = '0;
    endcase
  end

endmodule

//--- hdl/tcdm_pkg.sv
/* shared widths, atomic opcodes, response metadata and
   sequencer states for the memory-bank adapter */
package tcdm_pkg;

  // --------------------
  // widths
  // --------------------

  // data word of the bank, fixed
  localparam int unsigned data_width = 32;
  // one enable per byte of the word
  localparam int unsigned be_width = data_width / 8;
  // core identifier carried with every request
  localparam int unsigned core_id_width = 4;
  // transaction tag chosen by the requester
  localparam int unsigned tag_width = 4;

  // --------------------
  // request metadata
  // --------------------

  // returned unchanged next to the read data
  typedef struct packed {
    logic [core_id_width-1:0] core_id;
    logic [tag_width-1:0]     tag;
  } meta_t;

  // --------------------
  // opcodes
  // --------------------

  // none is a plain load or store
  typedef enum logic [3:0] {
    amo_none = 4'h0,
    amo_swap = 4'h1,
    amo_add  = 4'h2,
    amo_and  = 4'h3,
    amo_or   = 4'h4,
    amo_xor  = 4'h5,
    amo_max  = 4'h6,
    amo_maxu = 4'h7,
    amo_min  = 4'h8,
    amo_minu = 4'h9,
    amo_lr   = 4'hA,
    amo_sc   = 4'hB
  } amo_op_t;

  // atomic sequencer FSM
  typedef enum logic [1:0] {
    idle,
    do_amo,
    write_back
  } amo_state_t;

endpackage
